//--- source/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // major opcode, instruction bits 27..26
    typedef enum logic [1:0] {
        OP_DATA = 2'b00,
        OP_MEM  = 2'b01,
        OP_NOP  = 2'b10,
        OP_RSVD = 2'b11
    } op_kind_e;

    // data-processing cmd field, bits 24..21
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_SUB = 4'b0010,
        ALU_ADD = 4'b0100,
        ALU_ORR = 4'b1100
    } alu_op_e;

    typedef struct packed {
        op_kind_e  kind;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        reg_addr_t rd;
        reg_addr_t rn;
        reg_addr_t rm;
        word_t     imm;
    } decoded_instr_t;

    localparam reg_addr_t PC_REG         = 4'd15;
    // pipeline view of r15, two words ahead
    localparam word_t     PC_READ_OFFSET = 32'd8;
    localparam word_t     WORD_BYTES     = 32'd4;

endpackage

//--- source/mem_port_if.sv
interface mem_port_if;

    logic            req_valid;
    logic            req_write;
    core_pkg::word_t req_addr;
    core_pkg::word_t req_wdata;
    logic            req_ready;
    // read data, one pulse per read
    logic            rsp_valid;
    core_pkg::word_t rsp_rdata;

    modport requester (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport arbiter (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

//--- source/instr_stream_if.sv
interface instr_stream_if;

    logic            valid;
    logic            ready;
    core_pkg::word_t instr;
    // address the word was fetched from
    core_pkg::word_t pc;

    modport producer (output valid, instr, pc, input ready);

    modport consumer (input valid, instr, pc, output ready);

endinterface

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'h0
) (
    input  logic                clk,
    input  logic                reset,
    mem_port_if.requester       bus,
    instr_stream_if.producer    out
);

    core_pkg::word_t pc;
    core_pkg::word_t buf_instr;
    core_pkg::word_t buf_pc;
    logic            fetch_req;
    logic            fetch_pending;
    logic            buf_valid;

    // fetch is read only
    assign bus.req_valid = fetch_req;
    assign bus.req_write = 1'b0;
    assign bus.req_addr  = pc;
    assign bus.req_wdata = '0;

    assign out.valid = buf_valid;
    assign out.instr = buf_instr;
    assign out.pc    = buf_pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc            <= RESET_PC;
            fetch_req     <= 1'b0;
            fetch_pending <= 1'b0;
            buf_valid     <= 1'b0;
        end else begin
            // one fetch at a time, only into an empty buffer
            if (fetch_req) begin
                if (bus.req_ready) begin
                    fetch_req     <= 1'b0;
                    fetch_pending <= 1'b1;
                end
            end else if (!fetch_pending && !buf_valid) begin
                fetch_req <= 1'b1;
            end

            if (bus.rsp_valid) begin
                fetch_pending <= 1'b0;
                buf_valid     <= 1'b1;
                pc            <= pc + core_pkg::WORD_BYTES;
            end else if (out.valid && out.ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // buffer keeps the word together with its own address
    always_ff @(posedge clk) begin
        if (bus.rsp_valid) begin
            buf_instr <= bus.rsp_rdata;
            buf_pc    <= pc;
        end
    end

endmodule

//--- source/bus_arbiter.sv
module bus_arbiter (
    input  logic            clk,
    input  logic            reset,
    mem_port_if.arbiter     fetch_port,
    mem_port_if.arbiter     data_port,
    output logic            mem_req_valid,
    output logic            mem_req_write,
    output core_pkg::word_t mem_req_addr,
    output core_pkg::word_t mem_req_wdata,
    input  logic            mem_req_ready,
    input  logic            mem_rsp_valid,
    input  core_pkg::word_t mem_rsp_rdata
);

    logic gnt_locked;
    logic gnt_data;
    logic read_wait;
    logic read_owner_data;
    logic sel_data;
    logic handshake;

    //////////////////////////////////////////////////////////////////////
    // request steering

    // data side wins a fresh contest, a locked grant keeps its owner
    assign sel_data = gnt_locked ? gnt_data : data_port.req_valid;

    always_comb begin
        if (sel_data) begin
            mem_req_valid = data_port.req_valid && !read_wait;
            mem_req_write = data_port.req_write;
            mem_req_addr  = data_port.req_addr;
            mem_req_wdata = data_port.req_wdata;
        end else begin
            mem_req_valid = fetch_port.req_valid && !read_wait;
            mem_req_write = fetch_port.req_write;
            mem_req_addr  = fetch_port.req_addr;
            mem_req_wdata = fetch_port.req_wdata;
        end
    end

    assign handshake = mem_req_valid && mem_req_ready;

    assign data_port.req_ready  = mem_req_ready && !read_wait && sel_data;
    assign fetch_port.req_ready = mem_req_ready && !read_wait && !sel_data;

    //////////////////////////////////////////////////////////////////////
    // response routing

    assign data_port.rsp_valid  = mem_rsp_valid && read_wait && read_owner_data;
    assign fetch_port.rsp_valid = mem_rsp_valid && read_wait && !read_owner_data;
    assign data_port.rsp_rdata  = mem_rsp_rdata;
    assign fetch_port.rsp_rdata = mem_rsp_rdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gnt_locked      <= 1'b0;
            gnt_data        <= 1'b0;
            read_wait       <= 1'b0;
            read_owner_data <= 1'b0;
        end else begin
            if (handshake) begin
                gnt_locked <= 1'b0;
                // port stays closed until the read data is back
                if (!mem_req_write) begin
                    read_wait       <= 1'b1;
                    read_owner_data <= sel_data;
                end
            end else if (mem_req_valid) begin
                gnt_locked <= 1'b1;
                gnt_data   <= sel_data;
            end

            if (mem_rsp_valid) begin
                read_wait <= 1'b0;
            end
        end
    end

endmodule

//--- source/reg_file.sv
module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t     wd,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    input  core_pkg::word_t     pc_read,
    output core_pkg::word_t     rd1,
    output core_pkg::word_t     rd2
);

    // r0..r14, r15 is not stored
    core_pkg::word_t regs [0:14];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != core_pkg::PC_REG) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == core_pkg::PC_REG) ? pc_read : regs[ra1];
    assign rd2 = (ra2 == core_pkg::PC_REG) ? pc_read : regs[ra2];

endmodule

//--- source/instr_decoder.sv
module instr_decoder (
    input  core_pkg::word_t          instr,
    output core_pkg::decoded_instr_t dec
);

    always_comb begin
        dec      = '0;
        dec.kind = core_pkg::op_kind_e'(instr[27:26]);
        dec.rd   = instr[15:12];
        dec.rn   = instr[19:16];
        dec.rm   = instr[3:0];

        case (dec.kind)
            core_pkg::OP_DATA: begin
                dec.use_imm = instr[25];
                dec.imm     = {24'b0, instr[7:0]};
                case (instr[24:21])
                    core_pkg::ALU_AND,
                    core_pkg::ALU_SUB,
                    core_pkg::ALU_ADD,
                    core_pkg::ALU_ORR: begin
                        dec.alu_op = core_pkg::alu_op_e'(instr[24:21]);
                    end
                    // other commands retire without a write
                    default: begin
                        dec.kind = core_pkg::OP_NOP;
                    end
                endcase
            end
            core_pkg::OP_MEM: begin
                // address is rn + imm12, always added
                dec.alu_op   = core_pkg::ALU_ADD;
                dec.use_imm  = 1'b1;
                dec.imm      = {20'b0, instr[11:0]};
                dec.is_load  = instr[20];
                dec.is_store = ~instr[20];
            end
            default: begin
                dec.kind = core_pkg::OP_NOP;
            end
        endcase
    end

endmodule

//--- source/exec_unit.sv
module exec_unit (
    input  logic                clk,
    input  logic                reset,
    instr_stream_if.consumer    in,
    mem_port_if.requester       bus
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_REQ,
        S_WAIT
    } state_e;

    state_e                   state;
    core_pkg::word_t          instr_q;
    core_pkg::word_t          pc_q;
    core_pkg::word_t          ld_data;
    logic                     rsp_seen;
    core_pkg::decoded_instr_t dec;
    core_pkg::reg_addr_t      ra2;
    core_pkg::word_t          rd1;
    core_pkg::word_t          rd2;
    core_pkg::word_t          op_b;
    core_pkg::word_t          alu_res;
    logic                     mem_op;
    logic                     we;
    core_pkg::word_t          wd;

    instr_decoder u_decoder (
        .instr (instr_q),
        .dec   (dec)
    );

    // store data comes from rd on the second port
    assign ra2 = dec.is_store ? dec.rd : dec.rm;

    reg_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .we      (we),
        .wa      (dec.rd),
        .wd      (wd),
        .ra1     (dec.rn),
        .ra2     (ra2),
        .pc_read (pc_q + core_pkg::PC_READ_OFFSET),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    //////////////////////////////////////////////////////////////////////
    // alu, also forms the memory address

    assign op_b = dec.use_imm ? dec.imm : rd2;

    always_comb begin
        case (dec.alu_op)
            core_pkg::ALU_AND: alu_res = rd1 & op_b;
            core_pkg::ALU_SUB: alu_res = rd1 - op_b;
            core_pkg::ALU_ORR: alu_res = rd1 | op_b;
            default:           alu_res = rd1 + op_b;
        endcase
    end

    assign mem_op = dec.is_load || dec.is_store;

    assign in.ready = (state == S_IDLE);

    assign bus.req_valid = (state == S_EXEC || state == S_REQ) && mem_op;
    assign bus.req_write = dec.is_store;
    assign bus.req_addr  = alu_res;
    assign bus.req_wdata = rd2;

    // writeback, alu result or the captured load word
    assign we = (state == S_EXEC && dec.kind == core_pkg::OP_DATA) ||
                (state == S_WAIT && rsp_seen);
    assign wd = (state == S_WAIT) ? ld_data : alu_res;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            rsp_seen <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in.valid) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC, S_REQ: begin
                    if (!mem_op) begin
                        state <= S_IDLE;
                    end else if (bus.req_ready) begin
                        state <= dec.is_load ? S_WAIT : S_IDLE;
                    end else begin
                        state <= S_REQ;
                    end
                end
                S_WAIT: begin
                    if (rsp_seen) begin
                        rsp_seen <= 1'b0;
                        state    <= S_IDLE;
                    end else if (bus.rsp_valid) begin
                        rsp_seen <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            instr_q <= in.instr;
            pc_q    <= in.pc;
        end
        if (bus.rsp_valid) begin
            ld_data <= bus.rsp_rdata;
        end
    end

endmodule

//--- source/arm_lite_core.sv
module arm_lite_core #(
    parameter core_pkg::word_t RESET_PC = 32'h0
) (
    input  logic            clk,
    input  logic            reset,
    output logic            mem_req_valid,
    output logic            mem_req_write,
    output core_pkg::word_t mem_req_addr,
    output core_pkg::word_t mem_req_wdata,
    input  logic            mem_req_ready,
    input  logic            mem_rsp_valid,
    input  core_pkg::word_t mem_rsp_rdata
);

    mem_port_if     fetch_bus ();
    mem_port_if     data_bus ();
    instr_stream_if instr_stream ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk   (clk),
        .reset (reset),
        .bus   (fetch_bus.requester),
        .out   (instr_stream.producer)
    );

    exec_unit u_exec (
        .clk   (clk),
        .reset (reset),
        .in    (instr_stream.consumer),
        .bus   (data_bus.requester)
    );

    // single external port shared by fetch and data
    bus_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .fetch_port    (fetch_bus.arbiter),
        .data_port     (data_bus.arbiter),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

endmodule

//--- tests/core_bus_assert.sv
module core_bus_assert (
    input logic            clk,
    input logic            reset,
    input logic            mem_req_valid,
    input logic            mem_req_write,
    input core_pkg::word_t mem_req_addr,
    input core_pkg::word_t mem_req_wdata,
    input logic            mem_req_ready,
    input logic            mem_rsp_valid,
    input logic            fetch_valid,
    input core_pkg::word_t fetch_addr,
    input logic            fetch_ready,
    input logic            data_valid,
    input logic            data_write,
    input core_pkg::word_t data_addr,
    input logic            data_ready
);

    logic read_open;
    int   fail_count = 0;

    // read accepted on the external port, data not back yet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_open <= 1'b0;
        end else if (mem_rsp_valid) begin
            read_open <= 1'b0;
        end else if (mem_req_valid && mem_req_ready && !mem_req_write) begin
            read_open <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // external port protocol

    req_held: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_write) &&
            $stable(mem_req_addr) && $stable(mem_req_wdata)
    ) else begin
        $error("external request dropped or changed before ready");
        fail_count++;
    end

    no_req_during_read: assert property (
        @(posedge clk) disable iff (reset)
        read_open |-> !mem_req_valid
    ) else begin
        $error("new request while a read is outstanding");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // ready only reaches the side whose request is on the port

    fetch_ready_granted: assert property (
        @(posedge clk) disable iff (reset)
        fetch_ready && fetch_valid |->
            mem_req_valid && !mem_req_write && mem_req_addr == fetch_addr
    ) else begin
        $error("fetch side got ready without the grant");
        fail_count++;
    end

    data_ready_granted: assert property (
        @(posedge clk) disable iff (reset)
        data_ready |->
            data_valid && mem_req_valid &&
            mem_req_write == data_write && mem_req_addr == data_addr
    ) else begin
        $error("data side got ready without the grant");
        fail_count++;
    end

endmodule

bind bus_arbiter core_bus_assert bus_checks (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .fetch_valid   (fetch_port.req_valid),
    .fetch_addr    (fetch_port.req_addr),
    .fetch_ready   (fetch_port.req_ready),
    .data_valid    (data_port.req_valid),
    .data_write    (data_port.req_write),
    .data_addr     (data_port.req_addr),
    .data_ready    (data_port.req_ready)
);

//--- tests/core_tb.sv
module core_tb;

    localparam core_pkg::word_t PROG_BASE = 32'h0000_0100;
    localparam core_pkg::word_t DATA_BASE = 32'h0000_0200;
    localparam int              MEM_WORDS = 256;
    localparam int              TIMEOUT   = 4000;

    logic            clk;
    logic            reset;
    logic            mem_req_valid;
    logic            mem_req_write;
    core_pkg::word_t mem_req_addr;
    core_pkg::word_t mem_req_wdata;
    logic            mem_req_ready;
    logic            mem_rsp_valid;
    core_pkg::word_t mem_rsp_rdata;

    // memory model state
    core_pkg::word_t mem [0:MEM_WORDS-1];
    core_pkg::word_t ref_mem [0:MEM_WORDS-1];
    logic            random_mode;
    logic            rsp_pending;
    logic [3:0]      rsp_delay;
    core_pkg::word_t rsp_addr;
    logic            first_seen;
    core_pkg::word_t next_fetch;
    logic [31:0]     lfsr = 32'd89752;

    core_pkg::word_t prog [$];
    core_pkg::word_t got_addr [$];
    core_pkg::word_t got_data [$];
    core_pkg::word_t exp_addr [$];
    core_pkg::word_t exp_data [$];

    arm_lite_core #(
        .RESET_PC (PROG_BASE)
    ) UUT (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    // galois lfsr, one step per bit taken
    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // op 10 encoding, so unused words execute as no-ops
    function automatic core_pkg::word_t fill_word(input core_pkg::word_t addr);
        return {4'hE, 2'b10, 6'b0, addr[19:0]};
    endfunction

    function automatic core_pkg::word_t data_reg_op(input logic [3:0] cmd,
            input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm);
        return {4'hE, 2'b00, 1'b0, cmd, 1'b0, rn, rd, 8'h00, rm};
    endfunction

    function automatic core_pkg::word_t data_imm_op(input logic [3:0] cmd,
            input logic [3:0] rd, input logic [3:0] rn, input logic [7:0] imm);
        return {4'hE, 2'b00, 1'b1, cmd, 1'b0, rn, rd, 4'h0, imm};
    endfunction

    // pre-indexed, offset added, no writeback
    function automatic core_pkg::word_t load_store_op(input logic load,
            input logic [3:0] rd, input logic [3:0] rn, input logic [11:0] off);
        return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
    endfunction

    task automatic report_mismatch(input string name, input core_pkg::word_t expected,
            input core_pkg::word_t actual);
        $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s at time %0t", what, $time);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model, decisions made on the falling edge

    always @(negedge clk) begin
        logic ready_now;
        if (reset) begin
            assert (!mem_req_valid)
                else report_mismatch("mem_req_valid", 32'd0, {31'd0, mem_req_valid});
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            rsp_pending = 1'b0;
            first_seen  = 1'b0;
            next_fetch  = PROG_BASE;
            got_addr.delete();
            got_data.delete();
        end else begin
            assert (UUT.u_arbiter.bus_checks.fail_count == 0)
                else report_failure("bus protocol assertion failed");
            mem_rsp_valid <= 1'b0;
            if (rsp_pending) begin
                if (rsp_delay == 4'd0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_rdata <= mem[rsp_addr[9:2]];
                    rsp_pending = 1'b0;
                end else begin
                    rsp_delay = rsp_delay - 4'd1;
                end
            end
            ready_now = random_mode ? (rand_bits(1) == 4'd1) : 1'b1;
            mem_req_ready <= ready_now;
            if (mem_req_valid && !first_seen) begin
                first_seen = 1'b1;
                assert (mem_req_addr == PROG_BASE)
                    else report_mismatch("mem_req_addr", PROG_BASE, mem_req_addr);
                assert (!mem_req_write)
                    else report_failure("first request after reset is a write");
            end
            if (mem_req_valid && ready_now) begin
                if (mem_req_write) begin
                    mem[mem_req_addr[9:2]] = mem_req_wdata;
                    got_addr.push_back(mem_req_addr);
                    got_data.push_back(mem_req_wdata);
                end else begin
                    rsp_pending = 1'b1;
                    rsp_addr    = mem_req_addr;
                    rsp_delay   = random_mode ? rand_bits(2) : 4'd0;
                    // program area reads are fetches
                    if (mem_req_addr < DATA_BASE) begin
                        assert (mem_req_addr == next_fetch)
                            else report_mismatch("fetch mem_req_addr", next_fetch, mem_req_addr);
                        next_fetch = next_fetch + core_pkg::WORD_BYTES;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model, runs the program in order

    task automatic build_expected();
        core_pkg::word_t regs [0:15];
        core_pkg::word_t ins;
        core_pkg::word_t pc;
        core_pkg::word_t rn_val;
        core_pkg::word_t rm_val;
        core_pkg::word_t rd_val;
        core_pkg::word_t b;
        core_pkg::word_t res;
        core_pkg::word_t addr;
        logic            cmd_ok;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            pc     = PROG_BASE + i * 4;
            ins    = prog[i];
            rn_val = (ins[19:16] == 4'd15) ? pc + 32'd8 : regs[ins[19:16]];
            rd_val = (ins[15:12] == 4'd15) ? pc + 32'd8 : regs[ins[15:12]];
            rm_val = (ins[3:0] == 4'd15) ? pc + 32'd8 : regs[ins[3:0]];
            if (ins[27:26] == 2'b00) begin
                b      = ins[25] ? {24'h0, ins[7:0]} : rm_val;
                cmd_ok = 1'b1;
                res    = '0;
                case (ins[24:21])
                    4'b0000: res = rn_val & b;
                    4'b0010: res = rn_val - b;
                    4'b0100: res = rn_val + b;
                    4'b1100: res = rn_val | b;
                    default: cmd_ok = 1'b0;
                endcase
                if (cmd_ok && ins[15:12] != 4'd15) begin
                    regs[ins[15:12]] = res;
                end
            end else if (ins[27:26] == 2'b01) begin
                addr = rn_val + {20'h0, ins[11:0]};
                if (ins[20]) begin
                    if (ins[15:12] != 4'd15) begin
                        regs[ins[15:12]] = ref_mem[addr[9:2]];
                    end
                end else begin
                    ref_mem[addr[9:2]] = rd_val;
                    exp_addr.push_back(addr);
                    exp_data.push_back(rd_val);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // programs

    task automatic build_alu_program(input logic extras);
        prog.delete();
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd1, 4'd0, 8'h5A));
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd2, 4'd0, 8'h33));
        // r10 = 0x200, base of the store area
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd10, 4'd0, 8'h80));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd10, 4'd10, 4'd10));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd10, 4'd10, 4'd10));
        prog.push_back(data_reg_op(core_pkg::ALU_AND, 4'd3, 4'd1, 4'd2));
        if (extras) begin
            prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd15, 4'd1, 8'h04));
            // eor, not in the kept set
            prog.push_back(data_reg_op(4'b0001, 4'd3, 4'd3, 4'd1));
        end
        prog.push_back(load_store_op(1'b0, 4'd3, 4'd10, 12'h000));
        prog.push_back(data_reg_op(core_pkg::ALU_ORR, 4'd4, 4'd1, 4'd2));
        prog.push_back(load_store_op(1'b0, 4'd4, 4'd10, 12'h004));
        prog.push_back(data_reg_op(core_pkg::ALU_SUB, 4'd5, 4'd4, 4'd3));
        prog.push_back(load_store_op(1'b0, 4'd5, 4'd10, 12'h008));
        prog.push_back(data_imm_op(core_pkg::ALU_SUB, 4'd6, 4'd1, 8'h7F));
        if (extras) begin
            prog.push_back(32'hEC00_6001);
        end
        prog.push_back(load_store_op(1'b0, 4'd6, 4'd10, 12'h00C));
        prog.push_back(data_imm_op(core_pkg::ALU_AND, 4'd7, 4'd4, 8'h0F));
        prog.push_back(data_imm_op(core_pkg::ALU_ORR, 4'd8, 4'd5, 8'hC0));
        prog.push_back(load_store_op(1'b0, 4'd7, 4'd10, 12'h010));
        prog.push_back(load_store_op(1'b0, 4'd8, 4'd10, 12'h014));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd9, 4'd1, 4'd2));
        prog.push_back(load_store_op(1'b0, 4'd9, 4'd10, 12'h018));
    endtask

    task automatic build_load_program();
        prog.delete();
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd1, 4'd0, 8'h80));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd1, 4'd1, 4'd1));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd1, 4'd1, 4'd1));
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd2, 4'd0, 8'hC8));
        prog.push_back(load_store_op(1'b0, 4'd2, 4'd1, 12'h040));
        prog.push_back(load_store_op(1'b1, 4'd3, 4'd1, 12'h040));
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd4, 4'd3, 8'h11));
        prog.push_back(load_store_op(1'b0, 4'd4, 4'd1, 12'h044));
        prog.push_back(data_imm_op(core_pkg::ALU_ADD, 4'd5, 4'd15, 8'h00));
        prog.push_back(load_store_op(1'b0, 4'd5, 4'd1, 12'h048));
        prog.push_back(data_reg_op(core_pkg::ALU_ADD, 4'd6, 4'd15, 4'd0));
        prog.push_back(load_store_op(1'b0, 4'd6, 4'd1, 12'h04C));
        // untouched word comes back as the fill pattern
        prog.push_back(load_store_op(1'b1, 4'd7, 4'd1, 12'h080));
        prog.push_back(load_store_op(1'b0, 4'd7, 4'd1, 12'h050));
    endtask

    //////////////////////////////////////////////////////////////////////
    // run control

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i * 4);
            ref_mem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[(PROG_BASE >> 2) + i]     = prog[i];
            ref_mem[(PROG_BASE >> 2) + i] = prog[i];
        end
    endtask

    task automatic start_program(input logic rnd);
        @(negedge clk);
        reset <= 1'b1;
        @(negedge clk);
        random_mode = rnd;
        load_memory();
        build_expected();
        repeat (2) @(negedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_for_stores(input int count);
        int cycles;
        cycles = 0;
        while (got_addr.size() < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timed out waiting for stores");
            end
        end
    endtask

    task automatic compare_stores();
        for (int i = 0; i < exp_addr.size(); i++) begin
            assert (got_addr[i] == exp_addr[i])
                else report_mismatch("mem_req_addr", exp_addr[i], got_addr[i]);
            assert (got_data[i] == exp_data[i])
                else report_mismatch("mem_req_wdata", exp_data[i], got_data[i]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_reset_and_first_fetch();
        int cycles;
        build_alu_program(1'b0);
        start_program(1'b0);
        cycles = 0;
        while (!first_seen) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("no request after reset");
            end
        end
    endtask

    task automatic test_alu_stores();
        build_alu_program(1'b0);
        start_program(1'b0);
        wait_for_stores(exp_addr.size());
        compare_stores();
    endtask

    task automatic test_load_and_pc_read();
        build_load_program();
        start_program(1'b0);
        wait_for_stores(exp_addr.size());
        compare_stores();
    endtask

    // random ready and latency, r15 write and no-ops mixed in
    task automatic test_random_contention();
        build_alu_program(1'b1);
        start_program(1'b1);
        wait_for_stores(exp_addr.size());
        compare_stores();
    endtask

    initial begin
        reset         = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        random_mode   = 1'b0;
        test_reset_and_first_fetch();
        test_alu_stores();
        test_load_and_pc_read();
        test_random_contention();
        if (UUT.u_arbiter.bus_checks.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure("bus protocol assertion failed");
        end
    end

endmodule

//--- filelist.f
source/core_pkg.sv
source/mem_port_if.sv
source/instr_stream_if.sv
source/fetch_unit.sv
source/bus_arbiter.sv
source/reg_file.sv
source/instr_decoder.sv
source/exec_unit.sv
source/arm_lite_core.sv
tests/core_bus_assert.sv
tests/core_tb.sv
